//--- common/rp_bus_pkg.sv
/*
 * System bus definitions: widths, region map and register offsets
 */
`default_nettype none

package rp_bus_pkg;

  localparam int BUS_AW     = 32;  // byte address
  localparam int BUS_DW     = 32;  // full word, no byte select
  localparam int REGION_LSB = 20;  // region field is adr[22:20]
  localparam int REGION_W   = 3;   // eight regions
  localparam int OFS_W      = 8;   // register offset field adr[7:0]
  localparam int LED_W      = 8;

  // eight 1 MB windows, only hk and mixer populated
  typedef enum logic [REGION_W-1:0] {
    REG_HK  = 3'd0,
    REG_R1  = 3'd1,
    REG_MIX = 3'd2,
    REG_R3  = 3'd3,
    REG_R4  = 3'd4,
    REG_R5  = 3'd5,
    REG_R6  = 3'd6,
    REG_R7  = 3'd7
  } region_e;

  typedef enum logic [OFS_W-1:0] {HK_ID = 8'h00, HK_LED = 8'h04, HK_ADC = 8'h08} hk_reg_e;

  typedef enum logic [OFS_W-1:0] {MIX_OFS_A = 8'h00, MIX_OFS_B = 8'h04, MIX_CTRL = 8'h08} mix_reg_e;

endpackage

`default_nettype wire

//--- common/rp_analog_pkg.sv
/*
 * Analog data path definitions: sample format, saturation bounds and
 * the negative-slope code conversion shared by ADC and DAC side
 */
`default_nettype none

package rp_analog_pkg;

  localparam int SAMPLE_W = 14;                  // converter resolution
  localparam int SUM_W    = SAMPLE_W + 1;        // one guard bit for the adder

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement sample

  localparam sample_t SAT_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};  // +8191
  localparam sample_t SAT_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};  // -8192

  // negative-slope offset code <-> two's complement, the rule is its own inverse
  function automatic logic [SAMPLE_W-1:0] neg_slope_conv(logic [SAMPLE_W-1:0] code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};  // keep msb, flip the rest
  endfunction

endpackage

`default_nettype wire

//--- logic/bus_decoder.sv
/*
 * Bus decoder: splits the address space into eight regions, routes the
 * strobe, muxes the responses back and answers the empty regions itself
 */
`default_nettype none

module bus_decoder (
  input  wire logic                          adc_clk,
  input  wire logic                          reset_i,
  input  wire logic                          cyc_i,
  input  wire logic                          stb_i,
  input  wire logic                          we_i,
  input  wire logic [rp_bus_pkg::BUS_AW-1:0] adr_i,
  input  wire logic [rp_bus_pkg::BUS_DW-1:0] hk_rdata_i,
  input  wire logic [rp_bus_pkg::BUS_DW-1:0] mix_rdata_i,
  input  wire logic                          hk_ack_i,
  input  wire logic                          hk_err_i,
  input  wire logic                          mix_ack_i,
  input  wire logic                          mix_err_i,
  output logic                               hk_stb_o,
  output logic                               mix_stb_o,
  output logic      [rp_bus_pkg::BUS_DW-1:0] dat_o,
  output logic                               ack_o,
  output logic                               err_o
);
  import rp_bus_pkg::*;

  localparam int NUM_REG = 2 ** REGION_W;

  region_e              region;  // decoded address window
  logic                 req;     // valid bus cycle
  logic [NUM_REG-1:0]   sel_oh;  // one-hot region strobe
  logic                 um_req;  // strobe into an empty region
  logic                 um_ack;  // empty-slot response, single pulse

  assign region    = region_e'(adr_i[REGION_LSB +: REGION_W]);
  assign req       = cyc_i & stb_i;
  assign sel_oh    = req ? (NUM_REG'(1) << region) : '0;
  assign hk_stb_o  = sel_oh[REG_HK];
  assign mix_stb_o = sel_oh[REG_MIX];
  assign um_req    = req & ~(sel_oh[REG_HK] | sel_oh[REG_MIX]);

  // empty slot acks once per strobe, even while the master holds it
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      um_ack <= 1'b0;
    end else begin
      um_ack <= um_req & ~um_ack;
    end
  end

  // --------------------------------------------------
  // response mux, address is held until ack or err
  always_comb begin
    case (region)
      REG_HK: begin
        dat_o = hk_rdata_i;
        ack_o = hk_ack_i;
        err_o = hk_err_i;
      end
      REG_MIX: begin
        dat_o = mix_rdata_i;
        ack_o = mix_ack_i;
        err_o = mix_err_i;
      end
      default: begin
        dat_o = '0;      // empty region reads zero
        ack_o = um_ack;
        err_o = 1'b0;    // and never errs
      end
    endcase
  end

  // --------------------------------------------------
  a_resp_excl: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(ack_o && err_o));
  a_stb_onehot: assert property (@(posedge adc_clk) disable iff (reset_i)
    $onehot0({hk_stb_o, mix_stb_o}));
  a_um_wr_ack: assert property (@(posedge adc_clk) disable iff (reset_i)
    (um_req && we_i && !um_ack) |=> (ack_o && !err_o));

endmodule

`default_nettype wire

//--- logic/hk_regs.sv
/*
 * Housekeeping registers: board ID, LED control and ADC sample read-back
 */
`default_nettype none

module hk_regs #(
  parameter logic [rp_bus_pkg::BUS_DW-1:0] BOARD_ID = 32'h5250_0001
) (
  input  wire logic                             adc_clk,
  input  wire logic                             reset_i,
  input  wire logic                             stb_i,
  input  wire logic                             we_i,
  input  wire logic    [rp_bus_pkg::BUS_AW-1:0] adr_i,
  input  wire logic    [rp_bus_pkg::BUS_DW-1:0] dat_i,
  output logic         [rp_bus_pkg::BUS_DW-1:0] rdata_o,
  output logic                                  ack_o,
  output logic                                  err_o,
  input  wire rp_analog_pkg::sample_t           adc_a_i,
  input  wire rp_analog_pkg::sample_t           adc_b_i,
  output logic         [rp_bus_pkg::LED_W-1:0]  led_o
);
  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  localparam int HALF_W = BUS_DW / 2;  // one sample per half word

  logic              req;      // new access, not yet answered
  logic              bad_acc;  // undefined offset or ID write
  logic              wr_led;
  logic [BUS_DW-1:0] rd_val;
  logic [BUS_DW-1:0] adc_word;  // {b, a}, each sign extended

  assign req      = stb_i & ~(ack_o | err_o);
  assign adc_word = {{(HALF_W-SAMPLE_W){adc_b_i[SAMPLE_W-1]}}, adc_b_i,
                     {(HALF_W-SAMPLE_W){adc_a_i[SAMPLE_W-1]}}, adc_a_i};

  always_comb begin
    rd_val  = '0;
    bad_acc = 1'b0;
    wr_led  = 1'b0;
    case (adr_i[OFS_W-1:0])
      HK_ID: begin
        rd_val  = BOARD_ID;
        bad_acc = we_i;               // ID is read only
      end
      HK_LED: begin
        rd_val = {{(BUS_DW-LED_W){1'b0}}, led_o};
        wr_led = we_i;
      end
      HK_ADC:  rd_val = adc_word;     // writes ignored
      default: bad_acc = 1'b1;
    endcase
  end

  // --------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      led_o <= '0;
    end else begin
      ack_o <= req & ~bad_acc;  // one pulse per strobe
      err_o <= req & bad_acc;
      if (req && wr_led) begin
        led_o <= dat_i[LED_W-1:0];
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (req) begin
      rdata_o <= rd_val;  // valid with ack
    end
  end

  a_ack_after_stb: assert property (@(posedge adc_clk) disable iff (reset_i)
    ack_o |-> $past(stb_i));

endmodule

`default_nettype wire

//--- analog/adc_frontend.sv
/*
 * ADC front end: registers both channels and converts the
 * negative-slope codes to two's complement
 */
`default_nettype none

module adc_frontend (
  input  wire logic                                 adc_clk,
  input  wire logic                                 reset_i,
  input  wire logic [rp_analog_pkg::SAMPLE_W-1:0]   adc_dat_a_i,  // raw code ch a
  input  wire logic [rp_analog_pkg::SAMPLE_W-1:0]   adc_dat_b_i,  // raw code ch b
  output rp_analog_pkg::sample_t                    adc_a_o,
  output rp_analog_pkg::sample_t                    adc_b_o
);
  import rp_analog_pkg::*;

  // --------------------------------------------------
  // single capture stage, conversion folded in
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= sample_t'(neg_slope_conv(adc_dat_a_i));
      adc_b_o <= sample_t'(neg_slope_conv(adc_dat_b_i));
    end
  end

endmodule

`default_nettype wire

//--- analog/dac_mixer.sv
/*
 * DAC mixer: per-channel offset plus optional ADC sample, saturated to
 * 14 bits and registered out in DAC code format
 */
`default_nettype none

module dac_mixer (
  input  wire logic                               adc_clk,
  input  wire logic                               reset_i,
  input  wire logic                               stb_i,
  input  wire logic                               we_i,
  input  wire logic [rp_bus_pkg::BUS_AW-1:0]      adr_i,
  input  wire logic [rp_bus_pkg::BUS_DW-1:0]      dat_i,
  output logic      [rp_bus_pkg::BUS_DW-1:0]      rdata_o,
  output logic                                    ack_o,
  output logic                                    err_o,
  input  wire rp_analog_pkg::sample_t             adc_a_i,
  input  wire rp_analog_pkg::sample_t             adc_b_i,
  output logic      [rp_analog_pkg::SAMPLE_W-1:0] dac_a_o,  // DAC code
  output logic      [rp_analog_pkg::SAMPLE_W-1:0] dac_b_o
);
  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  localparam int CTRL_W = 2;  // [0] adc a -> ch a, [1] adc b -> ch b

  sample_t                  offset_a;
  sample_t                  offset_b;
  logic [CTRL_W-1:0]        ctrl;
  logic                     req;
  logic                     bad_ofs;
  logic [BUS_DW-1:0]        rd_val;
  sample_t                  sel_a;     // gated adc sample
  sample_t                  sel_b;
  logic signed [SUM_W-1:0]  sum_a;     // one guard bit
  logic signed [SUM_W-1:0]  sum_b;
  logic signed [SUM_W-1:0]  sat_a;
  logic signed [SUM_W-1:0]  sat_b;

  function automatic logic signed [SUM_W-1:0] clamp(logic signed [SUM_W-1:0] s);
    if (s > SAT_MAX) return SAT_MAX;
    if (s < SAT_MIN) return SAT_MIN;
    return s;
  endfunction

  assign req = stb_i & ~(ack_o | err_o);

  // --------------------------------------------------
  // register file
  always_comb begin
    rd_val  = '0;
    bad_ofs = 1'b0;
    case (adr_i[OFS_W-1:0])
      MIX_OFS_A: rd_val = {{(BUS_DW-SAMPLE_W){offset_a[SAMPLE_W-1]}}, offset_a};
      MIX_OFS_B: rd_val = {{(BUS_DW-SAMPLE_W){offset_b[SAMPLE_W-1]}}, offset_b};
      MIX_CTRL:  rd_val = {{(BUS_DW-CTRL_W){1'b0}}, ctrl};
      default:   bad_ofs = 1'b1;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      offset_a <= '0;
      offset_b <= '0;
      ctrl     <= '0;
    end else begin
      ack_o <= req & ~bad_ofs;
      err_o <= req & bad_ofs;
      if (req && we_i) begin
        case (adr_i[OFS_W-1:0])
          MIX_OFS_A: offset_a <= dat_i[SAMPLE_W-1:0];
          MIX_OFS_B: offset_b <= dat_i[SAMPLE_W-1:0];
          MIX_CTRL:  ctrl     <= dat_i[CTRL_W-1:0];
          default:   ;  // answered with err
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (req) begin
      rdata_o <= rd_val;
    end
  end

  // --------------------------------------------------
  // data path, sign extended add then clamp
  assign sel_a = ctrl[0] ? adc_a_i : sample_t'(0);
  assign sel_b = ctrl[1] ? adc_b_i : sample_t'(0);
  assign sum_a = offset_a + sel_a;
  assign sum_b = offset_b + sel_b;
  assign sat_a = clamp(sum_a);
  assign sat_b = clamp(sum_b);

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dac_a_o <= neg_slope_conv('0);  // code of zero
      dac_b_o <= neg_slope_conv('0);
    end else begin
      dac_a_o <= neg_slope_conv(sat_a[SAMPLE_W-1:0]);
      dac_b_o <= neg_slope_conv(sat_b[SAMPLE_W-1:0]);
    end
  end

  a_sat_range: assert property (@(posedge adc_clk) disable iff (reset_i)
    (sat_a <= SAT_MAX) && (sat_a >= SAT_MIN) && (sat_b <= SAT_MAX) && (sat_b >= SAT_MIN));

endmodule

`default_nettype wire

//--- logic/rp_top.sv
/*
 * Board top level: bus decoder, housekeeping and mixer register blocks
 * and the ADC to DAC data path, all on adc_clk
 */
`default_nettype none

module rp_top #(
  parameter logic [rp_bus_pkg::BUS_DW-1:0] BOARD_ID = 32'h5250_0001
) (
  input  wire logic                               adc_clk,
  input  wire logic                               reset_i,
  input  wire logic                               cyc_i,
  input  wire logic                               stb_i,
  input  wire logic                               we_i,
  input  wire logic [rp_bus_pkg::BUS_AW-1:0]      adr_i,
  input  wire logic [rp_bus_pkg::BUS_DW-1:0]      dat_i,
  output logic      [rp_bus_pkg::BUS_DW-1:0]      dat_o,
  output logic                                    ack_o,
  output logic                                    err_o,
  input  wire logic [rp_analog_pkg::SAMPLE_W-1:0] adc_dat_a_i,
  input  wire logic [rp_analog_pkg::SAMPLE_W-1:0] adc_dat_b_i,
  output logic      [rp_analog_pkg::SAMPLE_W-1:0] dac_a_o,
  output logic      [rp_analog_pkg::SAMPLE_W-1:0] dac_b_o,
  output logic      [rp_bus_pkg::LED_W-1:0]       led_o
);
  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  logic              hk_stb, mix_stb;
  logic [BUS_DW-1:0] hk_rdata, mix_rdata;
  logic              hk_ack, hk_err;
  logic              mix_ack, mix_err;
  sample_t           adc_a, adc_b;  // converted samples

  // --------------------------------------------------
  bus_decoder u_dec (
    .adc_clk, .reset_i, .cyc_i, .stb_i, .we_i, .adr_i,
    .hk_rdata_i (hk_rdata),  .mix_rdata_i (mix_rdata),
    .hk_ack_i   (hk_ack),    .hk_err_i    (hk_err),
    .mix_ack_i  (mix_ack),   .mix_err_i   (mix_err),
    .hk_stb_o   (hk_stb),    .mix_stb_o   (mix_stb),
    .dat_o, .ack_o, .err_o
  );

  hk_regs #(.BOARD_ID(BOARD_ID)) u_hk (       // region 0
    .adc_clk, .reset_i,
    .stb_i   (hk_stb), .we_i, .adr_i, .dat_i,
    .rdata_o (hk_rdata), .ack_o (hk_ack), .err_o (hk_err),
    .adc_a_i (adc_a),    .adc_b_i (adc_b),  .led_o
  );

  // --------------------------------------------------
  adc_frontend u_adc (
    .adc_clk, .reset_i, .adc_dat_a_i, .adc_dat_b_i,
    .adc_a_o (adc_a), .adc_b_o (adc_b)
  );

  dac_mixer u_mix (                           // region 2
    .adc_clk, .reset_i,
    .stb_i   (mix_stb), .we_i, .adr_i, .dat_i,
    .rdata_o (mix_rdata), .ack_o (mix_ack), .err_o (mix_err),
    .adc_a_i (adc_a),     .adc_b_i (adc_b),
    .dac_a_o, .dac_b_o
  );

endmodule

`default_nettype wire

//--- test/tb_rp_top.sv
/*
 * Testbench for the board top level: directed bus, register and data path tests
 */
`default_nettype none

module tb_rp_top;
  timeunit 1ns;
  timeprecision 100ps;

  import rp_bus_pkg::*;

  localparam logic [31:0] BOARD_ID   = 32'h5250_2a17;
  localparam int          MAX_CYCLES = 2000;          // ~45 bus cycles x 3 + settles < 600
  localparam int          RESP_WAIT  = 8;             // cycles before a response counts as lost
  localparam logic [31:0] HK_BASE    = 32'h0000_0000; // region 0
  localparam logic [31:0] MIX_BASE   = 32'h0020_0000; // region 2
  localparam logic [13:0] DAC_ZERO   = 14'h1fff;      // DAC code of 0
  localparam int          RESP_NONE  = 0;
  localparam int          RESP_ACK   = 1;
  localparam int          RESP_ERR   = 2;

  logic        adc_clk;
  logic        reset_i;
  logic        cyc_i;
  logic        stb_i;
  logic        we_i;
  logic [31:0] adr_i;
  logic [31:0] dat_i;
  logic [31:0] dat_o;
  logic        ack_o;
  logic        err_o;
  logic [13:0] adc_dat_a_i;
  logic [13:0] adc_dat_b_i;
  logic [13:0] dac_a_o;
  logic [13:0] dac_b_o;
  logic [7:0]  led_o;

  int    seed      = 32'h4f4;
  int    cycles    = 0;
  int    errors    = 0;
  int    tests     = 0;
  int    test_errs = 0;
  string cur_test  = "none";

  rp_top #(.BOARD_ID(BOARD_ID)) uut (
    .adc_clk, .reset_i, .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .dat_o, .ack_o, .err_o,
    .adc_dat_a_i, .adc_dat_b_i, .dac_a_o, .dac_b_o, .led_o
  );

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;  // 4 ns period
  end

  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped, timeout after %0d cycles", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // --------------------------------------------------
  // reference model, straight from the conversion and clamp rules
  function automatic logic [13:0] raw_for(int s);  // raw ADC code giving sample s
    return 14'(s) ^ 14'h1fff;
  endfunction

  function automatic int sample_of(logic [13:0] raw);
    logic [13:0] t;
    t = raw ^ 14'h1fff;                        // top bit kept, low 13 flipped
    return t[13] ? int'(t) - 16384 : int'(t);
  endfunction

  function automatic logic [13:0] expected_dac(int v);
    int c;
    c = v;
    if (c > 8191) c = 8191;
    if (c < -8192) c = -8192;
    return 14'(c) ^ 14'h1fff;
  endfunction

  // --------------------------------------------------
  task automatic mismatch(input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED %s expected %h actual %h", cur_test, exp, act);
    errors++;
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test;
    tests++;
    if (test_errs == 0) $display("test %s: ok", cur_test);
    else $display("test %s: %0d errors", cur_test, test_errs);
  endtask

  // one classic cycle, strobe held until ack or err
  task automatic bus_cycle(input logic wr, input logic [31:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat, output int resp);
    int n;
    @(posedge adc_clk);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= wr;
    adr_i <= adr;
    dat_i <= wdat;
    resp = RESP_NONE;
    rdat = '0;
    n    = 0;
    while (resp == RESP_NONE && n < RESP_WAIT) begin
      @(negedge adc_clk);                      // responses settled mid cycle
      if (ack_o) resp = RESP_ACK;
      else if (err_o) resp = RESP_ERR;
      rdat = dat_o;
      n++;
    end
    @(posedge adc_clk);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
    if (resp == RESP_NONE) begin
      $display("%s: no ack or err from the bus at address %h", cur_test, adr);
      errors++;
      test_errs++;
    end
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] wdat, output int resp);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdat, unused, resp);
  endtask

  task automatic read_word(input logic [31:0] adr, output logic [31:0] rdat, output int resp);
    bus_cycle(1'b0, adr, 32'h0, rdat, resp);
  endtask

  // program both channels, then compare the settled DAC codes
  task automatic mix_case(input int ofs_a, input int ofs_b, input logic [1:0] ctrl,
                          input int sa, input int sb);
    int          resp;
    logic [13:0] exp_a;
    logic [13:0] exp_b;
    @(posedge adc_clk);
    adc_dat_a_i <= raw_for(sa);
    adc_dat_b_i <= raw_for(sb);
    write_word(MIX_BASE | 32'(MIX_OFS_A), 32'(ofs_a), resp);
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    write_word(MIX_BASE | 32'(MIX_OFS_B), 32'(ofs_b), resp);
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    write_word(MIX_BASE | 32'(MIX_CTRL), {30'h0, ctrl}, resp);
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    repeat (3) @(posedge adc_clk);             // write + mixer stage
    @(negedge adc_clk);
    exp_a = expected_dac(ofs_a + (ctrl[0] ? sa : 0));
    exp_b = expected_dac(ofs_b + (ctrl[1] ? sb : 0));
    if (dac_a_o !== exp_a) mismatch({18'h0, exp_a}, {18'h0, dac_a_o});
    if (dac_b_o !== exp_b) mismatch({18'h0, exp_b}, {18'h0, dac_b_o});
  endtask

  // --------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic [13:0] raw_a;
    logic [13:0] raw_b;
    int          resp;
    reset_i     = 1'b1;
    cyc_i       = 1'b0;
    stb_i       = 1'b0;
    we_i        = 1'b0;
    adr_i       = '0;
    dat_i       = '0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    repeat (5) @(posedge adc_clk);
    reset_i <= 1'b0;

    begin_test("reset");
    @(negedge adc_clk);
    if (dac_a_o !== DAC_ZERO) mismatch({18'h0, DAC_ZERO}, {18'h0, dac_a_o});
    if (dac_b_o !== DAC_ZERO) mismatch({18'h0, DAC_ZERO}, {18'h0, dac_b_o});
    if (led_o !== 8'h00) mismatch(32'h0, {24'h0, led_o});
    read_word(HK_BASE | 32'(HK_ID), rd, resp);
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    if (rd !== BOARD_ID) mismatch(BOARD_ID, rd);
    end_test();

    begin_test("led");
    write_word(HK_BASE | 32'(HK_LED), 32'h1234_56a5, resp);  // only low byte kept
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    read_word(HK_BASE | 32'(HK_LED), rd, resp);
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    if (rd !== 32'h0000_00a5) mismatch(32'h0000_00a5, rd);
    @(negedge adc_clk);
    if (led_o !== 8'ha5) mismatch(32'ha5, {24'h0, led_o});
    write_word(HK_BASE | 32'(HK_ID), 32'hdead_beef, resp);  // read only
    if (resp != RESP_ERR) mismatch(RESP_ERR, resp);
    @(negedge adc_clk);
    if (led_o !== 8'ha5) mismatch(32'ha5, {24'h0, led_o});  // rejected write lands nowhere
    read_word(HK_BASE | 32'(HK_ID), rd, resp);
    if (rd !== BOARD_ID) mismatch(BOARD_ID, rd);
    read_word(HK_BASE | 32'h0000_000c, rd, resp);
    if (resp != RESP_ERR) mismatch(RESP_ERR, resp);
    end_test();

    begin_test("adc");
    repeat (6) begin
      raw_a = 14'($random(seed));
      raw_b = 14'($random(seed));
      @(posedge adc_clk);
      adc_dat_a_i <= raw_a;
      adc_dat_b_i <= raw_b;
      repeat (2) @(posedge adc_clk);           // capture stage
      read_word(HK_BASE | 32'(HK_ADC), rd, resp);
      if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
      if (rd !== {16'(sample_of(raw_b)), 16'(sample_of(raw_a))})
        mismatch({16'(sample_of(raw_b)), 16'(sample_of(raw_a))}, rd);
    end
    end_test();

    begin_test("mixer");
    mix_case(100, -200, 2'b11, 1500, -3000);
    mix_case(8000, 7000, 2'b11, 500, 4000);    // both clip high
    mix_case(-8000, -100, 2'b11, -1000, -8192); // both clip low
    mix_case(-4000, 3000, 2'b01, 2000, 5000);  // b disabled
    end_test();

    begin_test("unmapped");
    read_word(32'h0010_0000, rd, resp);
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    if (rd !== 32'h0) mismatch(32'h0, rd);
    read_word(32'h0050_0008, rd, resp);
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    if (rd !== 32'h0) mismatch(32'h0, rd);
    write_word(32'h0070_0004, 32'h0000_005a, resp);  // same offset as LED
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    write_word(32'h0070_0000, 32'h0000_0123, resp);  // same offset as ofs a
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    @(negedge adc_clk);
    if (led_o !== 8'ha5) mismatch(32'ha5, {24'h0, led_o});
    read_word(MIX_BASE | 32'(MIX_OFS_A), rd, resp);
    if (rd !== 32'(-4000)) mismatch(32'(-4000), rd);
    end_test();

    begin_test("mixer_readback");
    write_word(MIX_BASE | 32'(MIX_OFS_A), 32'h0000_3000, resp);  // -4096 in 14 bits
    read_word(MIX_BASE | 32'(MIX_OFS_A), rd, resp);
    if (resp != RESP_ACK) mismatch(RESP_ACK, resp);
    if (rd !== 32'hffff_f000) mismatch(32'hffff_f000, rd);
    write_word(MIX_BASE | 32'(MIX_OFS_B), 32'h0000_0abc, resp);
    read_word(MIX_BASE | 32'(MIX_OFS_B), rd, resp);
    if (rd !== 32'h0000_0abc) mismatch(32'h0000_0abc, rd);
    write_word(MIX_BASE | 32'(MIX_CTRL), 32'h0000_0002, resp);
    read_word(MIX_BASE | 32'(MIX_CTRL), rd, resp);
    if (rd !== 32'h0000_0002) mismatch(32'h0000_0002, rd);
    read_word(MIX_BASE | 32'h0000_0010, rd, resp);
    if (resp != RESP_ERR) mismatch(RESP_ERR, resp);
    end_test();

    $display("tests run %0d, errors %0d, cycles %0d", tests, errors, cycles);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
common/rp_bus_pkg.sv
common/rp_analog_pkg.sv
logic/bus_decoder.sv
logic/hk_regs.sv
analog/adc_frontend.sv
analog/dac_mixer.sv
logic/rp_top.sv
test/tb_rp_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the testbench with Verilator, run it and look for the pass line in the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rp_top \
  -f sources.f -o tb_rp_top
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_rp_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  exit 0
fi
exit 1
